//--- Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0 -Wno-fatal
TOP        := tb_systolic_controller
FILELIST   := systolic_controller.f
OBJ_DIR    := obj_dir
PASS_MSG   := All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- result_writer.sv
`timescale 1ns/1ps

module result_writer #(
    parameter int RESULT_WIDTH = 16,
    parameter int ADDR_WIDTH   = 12
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_capture,
    input  systolic_pkg::tile_result_t i_tile_result,
    input  systolic_pkg::addr_t        i_base,
    input  systolic_pkg::addr_t        i_stride,
    output systolic_pkg::result_wr_t   o_wr,
    output logic                       o_written
);

    import systolic_pkg::*;

    logic                    active;
    logic [3:0]              wr_idx;
    logic [ADDR_WIDTH-1:0]   base_q;
    logic [ADDR_WIDTH-1:0]   stride_q;
    logic [ADDR_WIDTH-1:0]   row_off;
    logic [RESULT_WIDTH-1:0] tile_q [TILE_ELEMS];

    // Held tile and its placement
    always_ff @(posedge clk) begin
        if (i_capture) begin
            base_q   <= i_base;
            stride_q <= i_stride;
            for (int k = 0; k < TILE_ELEMS; k++) begin
                tile_q[k] <= i_tile_result[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            wr_idx <= '0;
        end else if (i_capture) begin
            active <= 1'b1;
            wr_idx <= '0;
        end else if (active) begin
            wr_idx <= wr_idx + 1'b1;
            if (wr_idx == 4'(TILE_ELEMS - 1)) begin
                active <= 1'b0;
            end
        end
    end

    assign row_off   = stride_q * ADDR_WIDTH'(wr_idx[3:2]);
    assign o_wr.en   = active;
    assign o_wr.we   = active;
    assign o_wr.addr = base_q + row_off + ADDR_WIDTH'(wr_idx[1:0]);
    assign o_wr.data = tile_q[wr_idx];
    assign o_written = active && (wr_idx == 4'(TILE_ELEMS - 1));

endmodule

//--- systolic_controller.f
systolic_pkg.sv
tile_loader.sv
tile_sequencer.sv
result_writer.sv
systolic_controller.sv
tb_array_model.sv
tb_systolic_controller.sv

//--- systolic_controller.sv
`timescale 1ns/1ps

module systolic_controller #(
    parameter int INPUT_WIDTH  = 16,
    parameter int RESULT_WIDTH = 16,
    parameter int ADDR_WIDTH   = 12
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_start,
    input  systolic_pkg::data_t        i_a_rdata,
    input  systolic_pkg::data_t        i_b_rdata,
    input  systolic_pkg::data_t        i_inst_rdata,
    input  logic                       i_ready_for_feed,
    input  logic                       i_tile_done,
    input  systolic_pkg::tile_result_t i_tile_result,
    output logic                       o_done,
    output systolic_pkg::mem_rd_t      o_a_rd,
    output systolic_pkg::mem_rd_t      o_b_rd,
    output systolic_pkg::mem_rd_t      o_inst_rd,
    output systolic_pkg::result_wr_t   o_result,
    output systolic_pkg::feed_t        o_feed
);

    import systolic_pkg::*;

    // A block rows are contiguous
    localparam addr_t A_STRIDE = addr_t'(VEC_LEN);

    logic       load;
    logic       a_loaded;
    logic       b_loaded;
    logic       capture;
    logic       written;
    logic [1:0] lane_sel;
    addr_t      a_base;
    addr_t      b_base;
    addr_t      b_stride;
    addr_t      out_base;
    addr_t      out_stride;
    lane_vec_t  a_lane;
    lane_vec_t  b_lane;
    feed_t      seq_feed;

    tile_sequencer #(
        .INPUT_WIDTH (INPUT_WIDTH),
        .ADDR_WIDTH  (ADDR_WIDTH)
    ) u_sequencer (
        .clk              (clk),
        .rst              (rst),
        .i_start          (i_start),
        .i_inst_rdata     (i_inst_rdata),
        .i_a_loaded       (a_loaded),
        .i_b_loaded       (b_loaded),
        .i_ready_for_feed (i_ready_for_feed),
        .i_tile_done      (i_tile_done),
        .i_written        (written),
        .o_done           (o_done),
        .o_inst           (o_inst_rd),
        .o_load           (load),
        .o_a_base         (a_base),
        .o_b_base         (b_base),
        .o_b_stride       (b_stride),
        .o_lane_sel       (lane_sel),
        .o_feed           (seq_feed),
        .o_capture        (capture),
        .o_out_base       (out_base),
        .o_out_stride     (out_stride)
    );

    tile_loader #(
        .INPUT_WIDTH  (INPUT_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .COLUMN_LANES (1'b1)
    ) u_a_loader (
        .clk        (clk),
        .rst        (rst),
        .i_load     (load),
        .i_base     (a_base),
        .i_stride   (A_STRIDE),
        .i_rdata    (i_a_rdata),
        .i_lane_sel (lane_sel),
        .o_rd       (o_a_rd),
        .o_lane     (a_lane),
        .o_loaded   (a_loaded)
    );

    tile_loader #(
        .INPUT_WIDTH  (INPUT_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .COLUMN_LANES (1'b0)
    ) u_b_loader (
        .clk        (clk),
        .rst        (rst),
        .i_load     (load),
        .i_base     (b_base),
        .i_stride   (b_stride),
        .i_rdata    (i_b_rdata),
        .i_lane_sel (lane_sel),
        .o_rd       (o_b_rd),
        .o_lane     (b_lane),
        .o_loaded   (b_loaded)
    );

    result_writer #(
        .RESULT_WIDTH (RESULT_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH)
    ) u_writer (
        .clk           (clk),
        .rst           (rst),
        .i_capture     (capture),
        .i_tile_result (i_tile_result),
        .i_base        (out_base),
        .i_stride      (out_stride),
        .o_wr          (o_result),
        .o_written     (written)
    );

    // Sequencer flags joined with the loader lanes
    assign o_feed.clear   = seq_feed.clear;
    assign o_feed.valid   = seq_feed.valid;
    assign o_feed.row_bus = a_lane;
    assign o_feed.col_bus = b_lane;

endmodule

//--- systolic_pkg.sv
package systolic_pkg;

    localparam int INPUT_WIDTH  = 16;
    localparam int RESULT_WIDTH = 16;
    localparam int ADDR_WIDTH   = 12;

    // Tile geometry
    localparam int VEC_LEN    = 4;
    localparam int TILE_ELEMS = VEC_LEN * VEC_LEN;

    typedef logic signed [INPUT_WIDTH-1:0] data_t;
    typedef logic [RESULT_WIDTH-1:0]       result_t;
    typedef logic [ADDR_WIDTH-1:0]         addr_t;

    // Lane i sits in element i
    typedef data_t [VEC_LEN-1:0] lane_vec_t;

    // Element index is row*VEC_LEN + col
    typedef result_t [TILE_ELEMS-1:0] tile_result_t;

    // Read request, data follows one cycle later
    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_t;

    typedef struct packed {
        logic    en;
        logic    we;
        addr_t   addr;
        result_t data;
    } result_wr_t;

    // Array drive
    typedef struct packed {
        logic      clear;
        logic      valid;
        lane_vec_t row_bus;
        lane_vec_t col_bus;
    } feed_t;

endpackage

//--- tb_array_model.sv
`timescale 1ns/1ps

module tb_array_model #(
    parameter int FRAC = 15
) (
    input  logic                       clk,
    input  logic                       rst,
    input  systolic_pkg::feed_t        i_feed,
    output logic                       o_tile_done,
    output systolic_pkg::tile_result_t o_tile_result
);

    import systolic_pkg::*;

    localparam int DONE_DELAY = 3;

    logic signed [39:0] acc [TILE_ELEMS];
    logic [1:0]         feed_cnt;
    int                 done_dly;

    function automatic logic signed [39:0] lane_product(input data_t a, input data_t b);
        return 40'(a) * 40'(b);
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            feed_cnt    <= '0;
            done_dly    <= 0;
            o_tile_done <= 1'b0;
            for (int k = 0; k < TILE_ELEMS; k++) begin
                acc[k] <= '0;
            end
        end else begin
            if (i_feed.clear) begin
                feed_cnt    <= '0;
                o_tile_done <= 1'b0;
                for (int k = 0; k < TILE_ELEMS; k++) begin
                    acc[k] <= '0;
                end
            end else if (i_feed.valid) begin
                feed_cnt <= feed_cnt + 2'd1;
                for (int i = 0; i < VEC_LEN; i++) begin
                    for (int j = 0; j < VEC_LEN; j++) begin
                        acc[i * VEC_LEN + j] <= acc[i * VEC_LEN + j]
                            + lane_product(i_feed.row_bus[i], i_feed.col_bus[j]);
                    end
                end
                if (feed_cnt == 2'd3) begin
                    done_dly <= DONE_DELAY - 1;
                end
            end
            // Done rises a fixed delay after the last feed step
            if (done_dly != 0) begin
                done_dly <= done_dly - 1;
                if (done_dly == 1) begin
                    o_tile_done <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < TILE_ELEMS; k++) begin
            o_tile_result[k] = result_t'(acc[k] >>> FRAC);
        end
    end

endmodule

//--- tb_systolic_controller.sv
`timescale 1ns/1ps

module tb_systolic_controller;

    import systolic_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int FRAC      = 15;
    localparam int TIMEOUT   = 5000;

    logic         clk;
    logic         rst;
    logic         start;
    logic         ready_for_feed;
    logic         tile_done;
    tile_result_t tile_result;
    data_t        a_rdata    = '0;
    data_t        b_rdata    = '0;
    data_t        inst_rdata = '0;
    logic         done;
    mem_rd_t      a_rd;
    mem_rd_t      b_rd;
    mem_rd_t      inst_rd;
    result_wr_t   result;
    feed_t        feed;

    data_t   a_mem [MEM_WORDS];
    data_t   b_mem [MEM_WORDS];
    data_t   inst_mem [16];
    result_t out_mem [MEM_WORDS];
    int      wr_marks [MEM_WORDS];
    logic    clr_marks;

    int   seed;
    int   a_reads    = 0;
    int   b_reads    = 0;
    int   inst_reads = 0;
    int   writes     = 0;
    int   clears     = 0;
    int   valids     = 0;
    int   run_len    = 0;
    logic clear_q    = 1'b0;
    int   a_mark;
    int   b_mark;
    int   inst_mark;
    int   wr_mark;
    int   clear_mark;
    int   valid_mark;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    systolic_controller #(
        .INPUT_WIDTH  (INPUT_WIDTH),
        .RESULT_WIDTH (RESULT_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH)
    ) dut_i (
        .clk              (clk),
        .rst              (rst),
        .i_start          (start),
        .i_a_rdata        (a_rdata),
        .i_b_rdata        (b_rdata),
        .i_inst_rdata     (inst_rdata),
        .i_ready_for_feed (ready_for_feed),
        .i_tile_done      (tile_done),
        .i_tile_result    (tile_result),
        .o_done           (done),
        .o_a_rd           (a_rd),
        .o_b_rd           (b_rd),
        .o_inst_rd        (inst_rd),
        .o_result         (result),
        .o_feed           (feed)
    );

    tb_array_model #(
        .FRAC (FRAC)
    ) model_i (
        .clk           (clk),
        .rst           (rst),
        .i_feed        (feed),
        .o_tile_done   (tile_done),
        .o_tile_result (tile_result)
    );

    // One-cycle read memories
    always @(posedge clk) begin
        if (a_rd.en) begin
            a_rdata <= a_mem[a_rd.addr[7:0]];
        end
        if (b_rd.en) begin
            b_rdata <= b_mem[b_rd.addr[7:0]];
        end
        if (inst_rd.en) begin
            inst_rdata <= inst_mem[inst_rd.addr[3:0]];
        end
    end

    // Output memory, activity counters and feed protocol checks
    always @(posedge clk) begin
        if (clr_marks) begin
            for (int k = 0; k < MEM_WORDS; k++) begin
                wr_marks[k] = 0;
            end
        end
        if (!rst) begin
            a_reads    += int'(a_rd.en);
            b_reads    += int'(b_rd.en);
            inst_reads += int'(inst_rd.en);
            clears     += int'(feed.clear);
            valids     += int'(feed.valid);
            if (result.en && result.we) begin
                if (int'(result.addr) >= MEM_WORDS) begin
                    $display("Output write to address %0d is outside the memory", result.addr);
                    abort_run();
                end
                writes++;
                out_mem[result.addr[7:0]]  = result.data;
                wr_marks[result.addr[7:0]] = wr_marks[result.addr[7:0]] + 1;
            end
            if (!ready_for_feed) begin
                check_value("o_feed.clear while stalled", 64'(feed.clear), 64'd0);
                check_value("o_feed.valid while stalled", 64'(feed.valid), 64'd0);
            end
            if (clear_q) begin
                check_value("o_feed.valid after clear", 64'(feed.valid), 64'd1);
            end
            if (feed.valid) begin
                run_len++;
            end else if (run_len != 0) begin
                check_value("o_feed.valid run length", 64'(run_len), 64'(VEC_LEN));
                run_len = 0;
            end
            clear_q = feed.clear;
        end
    end

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic fill_data();
        for (int k = 0; k < MEM_WORDS; k++) begin
            a_mem[k] = data_t'($random(seed) % 1024);
            b_mem[k] = data_t'($random(seed) % 1024);
        end
    endtask

    task automatic set_program(input int s0, input int s1, input int s2);
        for (int k = 0; k < 16; k++) begin
            inst_mem[k] = '0;
        end
        inst_mem[0] = data_t'(s0);
        inst_mem[1] = data_t'(s1);
        inst_mem[2] = data_t'(s2);
    endtask

    task automatic clear_marks();
        clr_marks = 1'b1;
        @(negedge clk);
        clr_marks = 1'b0;
    endtask

    task automatic mark_counts();
        a_mark     = a_reads;
        b_mark     = b_reads;
        inst_mark  = inst_reads;
        wr_mark    = writes;
        clear_mark = clears;
        valid_mark = valids;
    endtask

    task automatic check_counts(input int insts, input int tiles, input int words);
        check_value("instruction reads", 64'(inst_reads - inst_mark), 64'(insts));
        check_value("A reads", 64'(a_reads - a_mark), 64'(tiles * TILE_ELEMS));
        check_value("B reads", 64'(b_reads - b_mark), 64'(tiles * TILE_ELEMS));
        check_value("output writes", 64'(writes - wr_mark), 64'(words));
        check_value("o_feed.clear pulses", 64'(clears - clear_mark), 64'(tiles));
        check_value("o_feed.valid cycles", 64'(valids - valid_mark), 64'(tiles * VEC_LEN));
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timed out waiting for o_done to rise");
                abort_run();
            end
        end
    endtask

    task automatic run_program();
        start = 1'b1;
        @(negedge clk);
        check_value("o_done", 64'(done), 64'd0);
        start = 1'b0;
        wait_done();
    endtask

    // Holds ready low for n cycles after the A tile reads end
    task automatic stall_feed(input int n);
        int cycles;
        ready_for_feed = 1'b0;
        cycles = 0;
        while (a_rd.en !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timed out waiting for the A tile reads to start");
                abort_run();
            end
        end
        cycles = 0;
        while (a_rd.en !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timed out waiting for the A tile reads to end");
                abort_run();
            end
        end
        repeat (n) @(negedge clk);
        ready_for_feed = 1'b1;
    endtask

    // A row is contiguous, B column elements are size words apart
    function automatic result_t expected_word(input int a_row, input int b_col, input int size);
        longint acc;
        acc = 0;
        for (int k = 0; k < VEC_LEN; k++) begin
            acc += longint'(a_mem[8'(a_row + k)]) * longint'(b_mem[8'(b_col + k * size)]);
        end
        return result_t'(acc >>> FRAC);
    endfunction

    task automatic verify_block(input int a_ptr, input int b_ptr, input int o_ptr,
                                input int size);
        int      addr;
        result_t exp;
        for (int r = 0; r < size; r++) begin
            for (int c = 0; c < size; c++) begin
                addr = o_ptr + r * size + c;
                exp  = expected_word(a_ptr + (r / 4) * 16 + (r % 4) * 4,
                                     b_ptr + (c / 4) * 4 + (c % 4), size);
                check_value($sformatf("out_mem[%0d]", addr), 64'(out_mem[8'(addr)]), 64'(exp));
                check_value($sformatf("writes to %0d", addr), 64'(wr_marks[8'(addr)]), 64'd1);
            end
        end
    endtask

    task automatic test_reset_and_empty();
        check_value("o_done", 64'(done), 64'd1);
        check_value("o_a_rd.en", 64'(a_rd.en), 64'd0);
        check_value("o_b_rd.en", 64'(b_rd.en), 64'd0);
        check_value("o_inst_rd.en", 64'(inst_rd.en), 64'd0);
        check_value("o_result.en", 64'(result.en), 64'd0);
        check_value("o_result.we", 64'(result.we), 64'd0);
        check_value("o_feed.clear", 64'(feed.clear), 64'd0);
        check_value("o_feed.valid", 64'(feed.valid), 64'd0);
        set_program(0, 0, 0);
        mark_counts();
        run_program();
        check_counts(1, 0, 0);
    endtask

    task automatic test_single_tile();
        set_program(4, 0, 0);
        clear_marks();
        mark_counts();
        run_program();
        check_counts(2, 1, 16);
        verify_block(0, 0, 0, 4);
    endtask

    task automatic test_four_tiles();
        set_program(8, 0, 0);
        clear_marks();
        mark_counts();
        run_program();
        check_counts(2, 4, 64);
        verify_block(0, 0, 0, 8);
    endtask

    task automatic test_two_instructions();
        set_program(4, 8, 0);
        clear_marks();
        mark_counts();
        run_program();
        check_counts(3, 5, 80);
        verify_block(0, 0, 0, 4);
        verify_block(16, 16, 16, 8);
    endtask

    task automatic test_feed_stall();
        set_program(4, 0, 0);
        clear_marks();
        mark_counts();
        fork
            run_program();
            stall_feed(20);
        join
        check_counts(2, 1, 16);
        verify_block(0, 0, 0, 4);
    endtask

    initial begin
        seed           = 17;
        rst            = 1'b1;
        start          = 1'b0;
        ready_for_feed = 1'b1;
        clr_marks      = 1'b0;
        fill_data();
        set_program(0, 0, 0);
        repeat (16) @(negedge clk);
        rst = 1'b0;
        test_reset_and_empty();
        test_single_tile();
        test_four_tiles();
        test_two_instructions();
        test_feed_stall();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- tile_loader.sv
`timescale 1ns/1ps

module tile_loader #(
    parameter int INPUT_WIDTH  = 16,
    parameter int ADDR_WIDTH   = 12,
    parameter bit COLUMN_LANES = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_load,
    input  systolic_pkg::addr_t    i_base,
    input  systolic_pkg::addr_t    i_stride,
    input  systolic_pkg::data_t    i_rdata,
    input  logic [1:0]             i_lane_sel,
    output systolic_pkg::mem_rd_t  o_rd,
    output systolic_pkg::lane_vec_t o_lane,
    output logic                   o_loaded
);

    import systolic_pkg::*;

    logic                          req_active;
    logic [3:0]                    req_cnt;
    logic [ADDR_WIDTH-1:0]         base_q;
    logic [ADDR_WIDTH-1:0]         stride_q;
    logic [ADDR_WIDTH-1:0]         row_off;
    logic                          cap_valid;
    logic [4:0]                    cap_cnt;
    logic signed [INPUT_WIDTH-1:0] tile_q [VEC_LEN][VEC_LEN];

    always_ff @(posedge clk) begin
        if (i_load) begin
            base_q   <= i_base;
            stride_q <= i_stride;
        end
    end

    // Request side, one read per cycle for 16 cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            req_active <= 1'b0;
            req_cnt    <= '0;
            cap_valid  <= 1'b0;
            cap_cnt    <= '0;
        end else begin
            cap_valid <= req_active;
            if (req_active) begin
                req_cnt <= req_cnt + 1'b1;
                if (req_cnt == 4'(TILE_ELEMS - 1)) begin
                    req_active <= 1'b0;
                end
            end
            if (i_load) begin
                req_active <= 1'b1;
                req_cnt    <= '0;
            end
            if (cap_valid) begin
                cap_cnt <= cap_cnt + 1'b1;
            end
            if (i_load) begin
                cap_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cap_valid) begin
            tile_q[cap_cnt[3:2]][cap_cnt[1:0]] <= i_rdata;
        end
    end

    assign row_off     = stride_q * ADDR_WIDTH'(req_cnt[3:2]);
    assign o_rd.en     = req_active;
    assign o_rd.addr   = base_q + row_off + ADDR_WIDTH'(req_cnt[1:0]);
    assign o_loaded    = cap_valid && (cap_cnt == 5'(TILE_ELEMS - 1));

    // A feeds a column per step, B a row
    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            if (COLUMN_LANES) begin
                o_lane[i] = tile_q[i][i_lane_sel];
            end else begin
                o_lane[i] = tile_q[i_lane_sel][i];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        cap_valid |-> cap_cnt < 5'(TILE_ELEMS));

endmodule

//--- tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer #(
    parameter int INPUT_WIDTH = 16,
    parameter int ADDR_WIDTH  = 12
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_start,
    input  systolic_pkg::data_t   i_inst_rdata,
    input  logic                  i_a_loaded,
    input  logic                  i_b_loaded,
    input  logic                  i_ready_for_feed,
    input  logic                  i_tile_done,
    input  logic                  i_written,
    output logic                  o_done,
    output systolic_pkg::mem_rd_t o_inst,
    output logic                  o_load,
    output systolic_pkg::addr_t   o_a_base,
    output systolic_pkg::addr_t   o_b_base,
    output systolic_pkg::addr_t   o_b_stride,
    output logic [1:0]            o_lane_sel,
    output systolic_pkg::feed_t   o_feed,
    output logic                  o_capture,
    output systolic_pkg::addr_t   o_out_base,
    output systolic_pkg::addr_t   o_out_stride
);

    import systolic_pkg::*;

    localparam int BLK_W = ADDR_WIDTH - 2;

    typedef enum logic [3:0] {
        S_IDLE, S_FETCH, S_WAIT, S_CHECK, S_LOAD,
        S_CLEAR, S_FEED, S_WAIT_TILE, S_WRITE, S_ADVANCE
    } state_t;

    state_t                 state;
    logic                   start_q;
    logic                   start_pulse;
    logic                   done_q;
    logic                   load_q;
    logic                   a_seen;
    logic                   b_seen;
    logic [INPUT_WIDTH-1:0] size_q;
    logic [ADDR_WIDTH-1:0]  size_a;
    logic [ADDR_WIDTH-1:0]  inst_ptr;
    logic [ADDR_WIDTH-1:0]  a_ptr;
    logic [ADDR_WIDTH-1:0]  b_ptr;
    logic [ADDR_WIDTH-1:0]  o_ptr;
    logic [BLK_W-1:0]       row_blk;
    logic [BLK_W-1:0]       col_blk;
    logic [BLK_W-1:0]       blk_last;
    logic [1:0]             feed_cnt;

    assign start_pulse = i_start & ~start_q;
    assign size_a      = size_q[ADDR_WIDTH-1:0];
    assign blk_last    = BLK_W'(size_a >> 2) - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            start_q  <= 1'b0;
            done_q   <= 1'b1;
            load_q   <= 1'b0;
            a_seen   <= 1'b0;
            b_seen   <= 1'b0;
            inst_ptr <= '0;
            a_ptr    <= '0;
            b_ptr    <= '0;
            o_ptr    <= '0;
            row_blk  <= '0;
            col_blk  <= '0;
            feed_cnt <= '0;
        end else begin
            start_q <= i_start;
            load_q  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_pulse) begin
                        done_q   <= 1'b0;
                        inst_ptr <= '0;
                        a_ptr    <= '0;
                        b_ptr    <= '0;
                        o_ptr    <= '0;
                        state    <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_WAIT;
                S_WAIT: begin
                    size_q <= i_inst_rdata;
                    state  <= S_CHECK;
                end
                S_CHECK: begin
                    if (size_q == '0) begin
                        done_q <= 1'b1;
                        state  <= S_IDLE;
                    end else begin
                        row_blk <= '0;
                        col_blk <= '0;
                        load_q  <= 1'b1;
                        state   <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    // Either loader may finish first
                    a_seen <= a_seen | i_a_loaded;
                    b_seen <= b_seen | i_b_loaded;
                    if ((a_seen | i_a_loaded) && (b_seen | i_b_loaded)) begin
                        a_seen <= 1'b0;
                        b_seen <= 1'b0;
                        state  <= S_CLEAR;
                    end
                end
                S_CLEAR: begin
                    if (i_ready_for_feed) begin
                        feed_cnt <= '0;
                        state    <= S_FEED;
                    end
                end
                S_FEED: begin
                    feed_cnt <= feed_cnt + 1'b1;
                    if (feed_cnt == 2'(VEC_LEN - 1)) begin
                        state <= S_WAIT_TILE;
                    end
                end
                S_WAIT_TILE: if (i_tile_done) state <= S_WRITE;
                S_WRITE:     if (i_written) state <= S_ADVANCE;
                S_ADVANCE: begin
                    if (col_blk != blk_last) begin
                        col_blk <= col_blk + 1'b1;
                        load_q  <= 1'b1;
                        state   <= S_LOAD;
                    end else if (row_blk != blk_last) begin
                        col_blk <= '0;
                        row_blk <= row_blk + 1'b1;
                        load_q  <= 1'b1;
                        state   <= S_LOAD;
                    end else begin
                        col_blk  <= '0;
                        row_blk  <= '0;
                        inst_ptr <= inst_ptr + 1'b1;
                        a_ptr    <= a_ptr + (size_a << 2);
                        b_ptr    <= b_ptr + (size_a << 2);
                        o_ptr    <= o_ptr + size_a * size_a;
                        state    <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign o_done      = done_q;
    assign o_inst.en   = (state == S_FETCH);
    assign o_inst.addr = inst_ptr;
    assign o_load      = load_q;

    // A block rows are 4 words apart, B and C rows are size apart
    assign o_a_base     = a_ptr + (ADDR_WIDTH'(row_blk) << 4);
    assign o_b_base     = b_ptr + (ADDR_WIDTH'(col_blk) << 2);
    assign o_b_stride   = size_a;
    assign o_out_base   = o_ptr + ((ADDR_WIDTH'(row_blk) * size_a) << 2)
                        + (ADDR_WIDTH'(col_blk) << 2);
    assign o_out_stride = size_a;

    assign o_lane_sel     = feed_cnt;
    assign o_feed.clear   = (state == S_CLEAR) && i_ready_for_feed;
    assign o_feed.valid   = (state == S_FEED);
    assign o_feed.row_bus = '0;
    assign o_feed.col_bus = '0;
    assign o_capture      = (state == S_WAIT_TILE) && i_tile_done;

    // Array cannot finish a tile while it is still being fed
    assert property (@(posedge clk) disable iff (rst)
        o_feed.valid |-> !i_tile_done);

    // Writer is busy for its 16 writes after each capture
    assert property (@(posedge clk) disable iff (rst)
        o_capture |=> !o_capture [*TILE_ELEMS]);

endmodule
